// ==== common/xosera_consts.svh ====
/*
 * widths and counts shared by the VRAM core
 * include wherever a width or port count is needed
 */

`ifndef XOSERA_CONSTS_SVH
`define XOSERA_CONSTS_SVH

`define XV_VRAM_ADDR_W  12      // word address, 4K words
`define XV_WORD_W       16      // VRAM data word
`define XV_NIBBLES      4       // write mask bits per word
`define XV_INTR_W       4       // interrupt sources

// capture slots, 0 = video, 1 = cpu
`define XV_READ_PORTS   2

`endif

// ==== common/xosera_pkg.sv ====
/*
 * shared vector types for the VRAM sharing core
 * import by wildcard in a module body, use scoped names in port lists
 */

`include "xosera_consts.svh"

package xosera_pkg;

    // VRAM word address
    typedef logic [`XV_VRAM_ADDR_W-1:0] vram_addr_t;

    // one VRAM data word
    typedef logic [`XV_WORD_W-1:0]      vram_word_t;

    // write enable per nibble, bit 0 covers bits 3:0
    typedef logic [`XV_NIBBLES-1:0]     nibble_mask_t;

    // one bit per interrupt source
    typedef logic [`XV_INTR_W-1:0]      intr_bits_t;

    // one bit per read capture slot
    typedef logic [`XV_READ_PORTS-1:0]  read_slots_t;

endpackage

// ==== common/vram_if.sv ====
/*
 * one VRAM access per cycle, from arbiter to memory
 * arbiter drives the request fields, memory returns rdata a cycle later
 */

`timescale 1ns/10ps

`include "xosera_consts.svh"

interface vram_if;

    logic                       sel;    // access this cycle
    logic                       wr;     // 1 = write, 0 = read
    logic [`XV_NIBBLES-1:0]     mask;   // nibble write enables
    logic [`XV_VRAM_ADDR_W-1:0] addr;   // word address
    logic [`XV_WORD_W-1:0]      wdata;  // word to write
    logic [`XV_WORD_W-1:0]      rdata;  // word read, one cycle late

    modport arbiter (
        output sel,
        output wr,
        output mask,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  sel,
        input  wr,
        input  mask,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== rtl/vram_arbiter/vram_arbiter.sv ====
/*
 * fixed priority VRAM arbiter, video then cpu then renderer
 * purely combinational, one requester steered onto the bus per cycle
 * read strobes go to the capture slots, which register them
 */

`timescale 1ns/10ps

module vram_arbiter (
    input  logic                    vid_sel_i,      // video fetch request, read only
    input  xosera_pkg::vram_addr_t  vid_addr_i,
    input  logic                    cpu_sel_i,      // cpu register port request
    input  logic                    cpu_wr_i,       // cpu write, else read
    input  xosera_pkg::nibble_mask_t cpu_mask_i,
    input  xosera_pkg::vram_addr_t  cpu_addr_i,
    input  xosera_pkg::vram_word_t  cpu_wdata_i,
    input  logic                    rndr_sel_i,     // renderer write request
    input  xosera_pkg::nibble_mask_t rndr_mask_i,
    input  xosera_pkg::vram_addr_t  rndr_addr_i,
    input  xosera_pkg::vram_word_t  rndr_wdata_i,
    output logic                    cpu_gnt_o,
    output logic                    rndr_gnt_o,     // draw enable
    output xosera_pkg::read_slots_t read_grant_o,   // per slot read strobe
    vram_if.arbiter                 mem
);

    import xosera_pkg::*;

    logic rndr_go;                  // renderer write actually issued

    // cpu loses only to video
    assign cpu_gnt_o  = cpu_sel_i && !vid_sel_i;

    // renderer may draw whenever the others are idle, whether or not it asks
    assign rndr_gnt_o = !vid_sel_i && !cpu_sel_i;
    assign rndr_go    = rndr_sel_i && rndr_gnt_o;

    // bus request
    assign mem.sel = vid_sel_i || cpu_sel_i || rndr_go;

    always_comb begin
        if (vid_sel_i) begin
            mem.wr   = 1'b0;                // video only reads
            mem.mask = '0;
            mem.addr = vid_addr_i;
        end else if (cpu_sel_i) begin
            mem.wr   = cpu_wr_i;
            mem.mask = cpu_mask_i;
            mem.addr = cpu_addr_i;
        end else begin
            mem.wr   = rndr_go;             // renderer never reads
            mem.mask = rndr_mask_i;
            mem.addr = rndr_addr_i;
        end
    end

    // write data only matters for cpu or renderer, video forces wr low
    assign mem.wdata = cpu_sel_i ? cpu_wdata_i : rndr_wdata_i;

    // slot 0 video, slot 1 cpu
    always_comb begin
        read_grant_o    = '0;
        read_grant_o[0] = vid_sel_i;
        read_grant_o[1] = cpu_gnt_o && !cpu_wr_i;   // granted cpu read only
    end

endmodule

// ==== rtl/vram_arbiter/read_capture.sv ====
/*
 * read result register for one requester
 * passes the memory word through in the load cycle, then holds it
 */

`timescale 1ns/10ps

module read_capture (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    rd_grant_i,     // read granted this cycle
    input  xosera_pkg::vram_word_t  mem_rdata_i,    // memory output
    output xosera_pkg::vram_word_t  data_o
);

    import xosera_pkg::*;

    logic       load;               // memory output is ours this cycle
    vram_word_t held;               // last word read

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load <= 1'b0;
        end else begin
            load <= rd_grant_i;
        end
    end

    // save word at end of load cycle
    always_ff @(posedge clk) begin
        if (load) begin
            held <= mem_rdata_i;
        end
    end

    assign data_o = load ? mem_rdata_i : held;  // no extra cycle on fresh data

endmodule

// ==== rtl/vram_array.sv ====
/*
 * single port synchronous VRAM, 2^XV_VRAM_ADDR_W words
 * writes merge only the masked nibbles, reads have one cycle latency
 */

`timescale 1ns/10ps

`include "xosera_consts.svh"

module vram_array (
    input  logic    clk,
    vram_if.memory  bus
);

    import xosera_pkg::*;

    localparam int NIB_W = `XV_WORD_W / `XV_NIBBLES;   // bits per mask bit
    localparam int DEPTH = 1 << `XV_VRAM_ADDR_W;

    vram_word_t mem [DEPTH];        // video memory
    vram_word_t rd_word;            // registered read

    always_ff @(posedge clk) begin
        if (bus.sel) begin
            if (bus.wr) begin
                for (int n = 0; n < `XV_NIBBLES; n++) begin
                    if (bus.mask[n]) begin
                        mem[bus.addr][n*NIB_W +: NIB_W] <= bus.wdata[n*NIB_W +: NIB_W];
                    end
                end
            end else begin
                rd_word <= mem[bus.addr];   // valid next cycle
            end
        end
    end

    assign bus.rdata = rd_word;

endmodule

// ==== rtl/intr_ctrl.sv ====
/*
 * interrupt controller with sticky pending bits
 * raises a one cycle cpu strobe for each new, enabled source
 */

`timescale 1ns/10ps

module intr_ctrl (
    input  logic                    clk,
    input  logic                    reset_i,
    input  xosera_pkg::intr_bits_t  signal_i,   // source pulses
    input  xosera_pkg::intr_bits_t  mask_i,     // 1 = enabled
    input  xosera_pkg::intr_bits_t  clear_i,    // cpu acknowledge
    output xosera_pkg::intr_bits_t  status_o,   // pending bits
    output logic                    bus_intr_o  // cpu interrupt strobe
);

    import xosera_pkg::*;

    intr_bits_t status;
    intr_bits_t fresh;              // signalled, enabled, not yet pending

    assign fresh = signal_i & mask_i & ~status;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            status     <= '0;
            bus_intr_o <= 1'b0;
        end else begin
            bus_intr_o <= |fresh;
            // set by signal, clear wins
            status     <= (status | signal_i) & ~clear_i;
        end
    end

    assign status_o = status;

endmodule

// ==== rtl/xosera_vram_top.sv ====
/*
 * VRAM sharing and interrupt core of the video controller
 * video, cpu and renderer share one VRAM by fixed priority
 * video and cpu reads come back through per port capture slots
 */

`timescale 1ns/10ps

`include "xosera_consts.svh"

module xosera_vram_top (
    input  logic                        clk,
    input  logic                        reset_i,
    // video fetch, always wins
    input  logic                        vid_sel_i,
    input  xosera_pkg::vram_addr_t      vid_addr_i,
    // cpu register port
    input  logic                        cpu_sel_i,
    input  logic                        cpu_wr_i,
    input  xosera_pkg::nibble_mask_t    cpu_mask_i,
    input  xosera_pkg::vram_addr_t      cpu_addr_i,
    input  xosera_pkg::vram_word_t      cpu_wdata_i,
    output logic                        cpu_gnt_o,
    // primitive renderer, writes only
    input  logic                        rndr_sel_i,
    input  xosera_pkg::nibble_mask_t    rndr_mask_i,
    input  xosera_pkg::vram_addr_t      rndr_addr_i,
    input  xosera_pkg::vram_word_t      rndr_wdata_i,
    output logic                        rndr_gnt_o,
    // read results
    output xosera_pkg::vram_word_t      vid_rdata_o,
    output xosera_pkg::vram_word_t      cpu_rdata_o,
    // interrupts
    input  xosera_pkg::intr_bits_t      intr_signal_i,
    input  xosera_pkg::intr_bits_t      intr_mask_i,
    input  xosera_pkg::intr_bits_t      intr_clear_i,
    output xosera_pkg::intr_bits_t      intr_status_o,
    output logic                        bus_intr_o
);

    import xosera_pkg::*;

    vram_if      vram_bus ();                   // arbiter to memory
    read_slots_t read_grant;                    // per slot read strobes
    vram_word_t  slot_rdata [`XV_READ_PORTS];   // capture slot outputs

    vram_arbiter arbiter_i (
        .vid_sel_i    (vid_sel_i),
        .vid_addr_i   (vid_addr_i),
        .cpu_sel_i    (cpu_sel_i),
        .cpu_wr_i     (cpu_wr_i),
        .cpu_mask_i   (cpu_mask_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .rndr_sel_i   (rndr_sel_i),
        .rndr_mask_i  (rndr_mask_i),
        .rndr_addr_i  (rndr_addr_i),
        .rndr_wdata_i (rndr_wdata_i),
        .cpu_gnt_o    (cpu_gnt_o),
        .rndr_gnt_o   (rndr_gnt_o),
        .read_grant_o (read_grant),
        .mem          (vram_bus.arbiter)
    );

    // one capture slot per reading requester
    for (genvar s = 0; s < `XV_READ_PORTS; s++) begin : g_slot
        read_capture capture_i (
            .clk         (clk),
            .reset_i     (reset_i),
            .rd_grant_i  (read_grant[s]),
            .mem_rdata_i (vram_bus.rdata),
            .data_o      (slot_rdata[s])
        );
    end

    assign vid_rdata_o = slot_rdata[0];
    assign cpu_rdata_o = slot_rdata[1];

    vram_array vram_i (
        .clk (clk),
        .bus (vram_bus.memory)
    );

    intr_ctrl intr_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .signal_i   (intr_signal_i),
        .mask_i     (intr_mask_i),
        .clear_i    (intr_clear_i),
        .status_o   (intr_status_o),
        .bus_intr_o (bus_intr_o)
    );

endmodule

// ==== tests/tb_xosera_vram.sv ====
/*
 * testbench for the VRAM sharing and interrupt core
 * directed and random traffic on all three requesters plus interrupts
 * a negedge checker keeps a shadow VRAM and checks every cycle with assertions
 */

`timescale 1ns/10ps

`include "xosera_consts.svh"

module tb_xosera_vram;

    import xosera_pkg::*;

    localparam int GRANT_TIMEOUT = 200;                     // cycles per grant wait
    localparam int NIB_W = `XV_WORD_W / `XV_NIBBLES;
    localparam int DEPTH = 1 << `XV_VRAM_ADDR_W;

    logic clk;
    logic reset_i;
    logic vid_sel_i, cpu_sel_i, cpu_wr_i, rndr_sel_i;
    vram_addr_t vid_addr_i, cpu_addr_i, rndr_addr_i;
    nibble_mask_t cpu_mask_i, rndr_mask_i;
    vram_word_t cpu_wdata_i, rndr_wdata_i;
    logic cpu_gnt_o, rndr_gnt_o, bus_intr_o;
    vram_word_t vid_rdata_o, cpu_rdata_o;
    intr_bits_t intr_signal_i, intr_mask_i, intr_clear_i, intr_status_o;

    vram_word_t shadow [DEPTH];     // expected VRAM contents
    vram_word_t exp_vid, exp_cpu;   // expected slot outputs
    logic       vid_valid, cpu_valid;
    intr_bits_t exp_status;
    logic       exp_intr;
    int errors, tests_run, tests_failed, errors_at_start;
    string test_name;
    vram_addr_t written_q [$];      // renderer targets to read back
    int unsigned seed_val;

    xosera_vram_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns
    end

    task automatic report_mismatch(input string what, input vram_word_t got,
                                   input vram_word_t exp);
        $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout waiting for %s grant", what);
        $display("Result: FAILED");
        $finish;
    endtask

    function automatic vram_word_t merge_nibbles(input vram_word_t old_w,
            input nibble_mask_t m, input vram_word_t new_w);
        vram_word_t w;
        int n;
        w = old_w;
        for (n = 0; n < `XV_NIBBLES; n++) begin
            if (m[n]) w[n*NIB_W +: NIB_W] = new_w[n*NIB_W +: NIB_W];
        end
        return w;
    endfunction

    // odd multiplier keeps every address bit in the word
    function automatic vram_word_t fill_word(input vram_addr_t a);
        return vram_word_t'(a) * 16'h9e37 ^ 16'h3c5a;
    endfunction

    // outputs and inputs have both settled by the falling edge
    always @(negedge clk) begin
        if (reset_i !== 1'b0) begin
            vid_valid  = 1'b0;
            cpu_valid  = 1'b0;
            exp_status = '0;
            exp_intr   = 1'b0;
        end else begin
            // results of the edge just passed and any held word
            if (vid_valid) assert (vid_rdata_o === exp_vid)
                else report_mismatch("video read data", vid_rdata_o, exp_vid);
            if (cpu_valid) assert (cpu_rdata_o === exp_cpu)
                else report_mismatch("cpu read data", cpu_rdata_o, exp_cpu);
            assert (intr_status_o === exp_status)
                else report_mismatch("interrupt status", intr_status_o, exp_status);
            assert (bus_intr_o === exp_intr)
                else report_mismatch("interrupt strobe", bus_intr_o, exp_intr);
            // grants for what is requested now
            assert (cpu_gnt_o === (cpu_sel_i && !vid_sel_i))
                else report_mismatch("cpu grant", cpu_gnt_o, cpu_sel_i && !vid_sel_i);
            assert (rndr_gnt_o === (!vid_sel_i && !cpu_sel_i))
                else report_mismatch("renderer grant", rndr_gnt_o, !vid_sel_i && !cpu_sel_i);
            // the one access taken at the coming edge
            if (vid_sel_i) begin
                exp_vid   = shadow[vid_addr_i];
                vid_valid = 1'b1;
            end else if (cpu_sel_i && cpu_wr_i) begin
                shadow[cpu_addr_i] = merge_nibbles(shadow[cpu_addr_i], cpu_mask_i, cpu_wdata_i);
            end else if (cpu_sel_i) begin
                exp_cpu   = shadow[cpu_addr_i];
                cpu_valid = 1'b1;
            end else if (rndr_sel_i) begin
                shadow[rndr_addr_i] = merge_nibbles(shadow[rndr_addr_i], rndr_mask_i,
                                                    rndr_wdata_i);
            end
            // strobe for a new enabled source not yet pending
            exp_intr   = |(intr_signal_i & intr_mask_i & ~exp_status);
            exp_status = (exp_status | intr_signal_i) & ~intr_clear_i;    // clear wins
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;                         // drive just after the edge
    endtask

    task automatic cpu_access(input logic wr, input nibble_mask_t m, input vram_addr_t a,
                              input vram_word_t d);
        int waited;
        cpu_sel_i   = 1'b1;
        cpu_wr_i    = wr;
        cpu_mask_i  = m;
        cpu_addr_i  = a;
        cpu_wdata_i = d;
        waited      = 0;
        #1;
        while (!cpu_gnt_o) begin    // inputs stay put until granted
            if (waited == GRANT_TIMEOUT) timeout_fail("cpu");
            waited++;
            next_cycle();
            #1;
        end
        next_cycle();
        cpu_sel_i = 1'b0;
        cpu_wr_i  = 1'b0;
    endtask

    task automatic vid_read(input vram_addr_t a);
        vid_sel_i  = 1'b1;          // never refused
        vid_addr_i = a;
        next_cycle();
        vid_sel_i  = 1'b0;
    endtask

    // renderer write held until granted under random video and optional cpu reads
    task automatic rndr_write(input nibble_mask_t m, input vram_addr_t a,
                              input vram_word_t d, input logic cpu_traffic);
        int   waited;
        logic granted;
        rndr_sel_i   = 1'b1;
        rndr_mask_i  = m;
        rndr_addr_i  = a;
        rndr_wdata_i = d;
        waited       = 0;
        granted      = 1'b0;
        while (!granted) begin
            vid_sel_i  = ($urandom_range(0, 1) == 1);
            vid_addr_i = vram_addr_t'($urandom);
            cpu_sel_i  = cpu_traffic && ($urandom_range(0, 2) == 0);
            cpu_addr_i = vram_addr_t'($urandom);
            #1;
            granted = rndr_gnt_o;
            next_cycle();           // write lands here only when granted
            if (!granted && waited == GRANT_TIMEOUT) timeout_fail("renderer");
            waited++;
        end
        rndr_sel_i = 1'b0;
        vid_sel_i  = 1'b0;
        cpu_sel_i  = 1'b0;
    endtask

    task automatic intr_pulse(input intr_bits_t sig, input intr_bits_t clr);
        intr_signal_i = sig;
        intr_clear_i  = clr;
        next_cycle();
        intr_signal_i = '0;
        intr_clear_i  = '0;
        next_cycle();               // strobe shows in this cycle
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        int         i;
        vram_addr_t a;
        seed_val     = $urandom(32'he8c1);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_i      = 1'b1;
        vid_sel_i    = 1'b0;
        vid_addr_i   = '0;
        cpu_sel_i    = 1'b0;
        cpu_wr_i     = 1'b0;
        cpu_mask_i   = '0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        rndr_sel_i   = 1'b0;
        rndr_mask_i  = '0;
        rndr_addr_i  = '0;
        rndr_wdata_i = '0;
        intr_signal_i = '0;
        intr_mask_i   = '0;
        intr_clear_i  = '0;
        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;

        begin_test("reset");
        @(negedge clk);
        assert (bus_intr_o === 1'b0 && intr_status_o === '0)
            else report_mismatch("interrupt state after reset", vram_word_t'(intr_status_o), '0);
        next_cycle();
        end_test();

        begin_test("prefill");      // whole VRAM gets a known word
        for (i = 0; i < DEPTH; i++) begin
            cpu_access(1'b1, '1, vram_addr_t'(i), fill_word(vram_addr_t'(i)));
        end
        end_test();

        begin_test("priority");
        vid_sel_i   = 1'b1;         // all three ask
        cpu_sel_i   = 1'b1;
        rndr_sel_i  = 1'b1;
        rndr_wdata_i = 16'hdead;
        next_cycle();
        vid_sel_i   = 1'b0;         // cpu beats renderer
        next_cycle();
        cpu_sel_i   = 1'b0;
        rndr_sel_i  = 1'b0;
        cpu_access(1'b0, '0, rndr_addr_i, '0);  // refused renderer word never landed
        for (i = 0; i < 16; i++) vid_read(vram_addr_t'($urandom));
        end_test();

        begin_test("masked writes");
        for (i = 0; i < 40; i++) begin
            a = vram_addr_t'($urandom);
            cpu_access(1'b1, nibble_mask_t'($urandom), a, vram_word_t'($urandom));
            cpu_access(1'b0, '0, a, '0);
        end
        end_test();

        begin_test("renderer back-pressure");
        for (i = 0; i < 30; i++) begin
            a = vram_addr_t'($urandom);
            written_q.push_back(a);
            rndr_write(nibble_mask_t'($urandom), a, vram_word_t'($urandom), 1'b1);
        end
        while (written_q.size() > 0) cpu_access(1'b0, '0, written_q.pop_front(), '0);
        end_test();

        begin_test("hold");
        a = vram_addr_t'($urandom);
        cpu_access(1'b0, '0, a, '0);
        for (i = 0; i < 8; i++) begin
            vid_read(vram_addr_t'($urandom));
            // first write hits the word just read
            rndr_write('1, (i == 0) ? a : vram_addr_t'($urandom),
                       vram_word_t'($urandom), 1'b0);
        end
        cpu_access(1'b0, '0, a, '0);    // now picks up the renderer word
        end_test();

        begin_test("interrupts");
        intr_mask_i = 4'b1011;
        intr_pulse(4'b0001, 4'b0000);   // new source strobes
        intr_pulse(4'b0001, 4'b0000);   // already pending
        intr_pulse(4'b0100, 4'b0000);   // masked source sets status only
        intr_pulse(4'b0000, 4'b0001);
        intr_pulse(4'b0010, 4'b0010);   // clear wins in the same cycle
        intr_pulse(4'b1000, 4'b0000);
        for (i = 0; i < 32; i++) begin
            if (i % 8 == 0) intr_mask_i = intr_bits_t'($urandom);
            intr_signal_i = intr_bits_t'($urandom);
            intr_clear_i  = intr_bits_t'($urandom) & intr_bits_t'($urandom);
            next_cycle();
        end
        intr_pulse(4'b0000, 4'b1111);
        end_test();

        repeat (2) next_cycle();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== xosera_vram.f ====
+incdir+common
common/xosera_pkg.sv
common/vram_if.sv
rtl/vram_arbiter/vram_arbiter.sv
rtl/vram_arbiter/read_capture.sv
rtl/vram_array.sv
rtl/intr_ctrl.sv
rtl/xosera_vram_top.sv
tests/tb_xosera_vram.sv

// ==== Bender.yml ====
package:
  name: xosera_vram

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/xosera_pkg.sv
      - common/vram_if.sv
      - rtl/vram_arbiter/vram_arbiter.sv
      - rtl/vram_arbiter/read_capture.sv
      - rtl/vram_array.sv
      - rtl/intr_ctrl.sv
      - rtl/xosera_vram_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_xosera_vram.sv
